// File: include/lsu_dctl_cfg.svh
// Thread count and field widths for the LSU control datapath; include before the package.
`ifndef LSU_DCTL_CFG_SVH
`define LSU_DCTL_CFG_SVH

// hardware threads
`define LSU_NUM_THREADS 4

// ASI register width
`define LSU_ASI_W 8

// primary and secondary context width
`define LSU_CTXT_W 13

// partition id width
`define LSU_PID_W 3

// load-alternate readback word
`define LSU_LDXA_W 48

// watchpoint byte mask
`define LSU_BMASK_W 8

// store data slice used by the register writes
`define LSU_ST_DATA_W 33

`endif

// File: hw/lsu_dctl_pkg.sv
// Shared types of the LSU control datapath; import into each block that needs them.
`default_nettype none

`include "lsu_dctl_cfg.svh"

package lsu_dctl_pkg;

   typedef logic [$clog2(`LSU_NUM_THREADS)-1:0] thread_id_t;

   typedef logic [`LSU_ASI_W-1:0]     asi_t;
   typedef logic [`LSU_CTXT_W-1:0]    ctxt_t;
   typedef logic [`LSU_PID_W-1:0]     pid_t;
   typedef logic [`LSU_ST_DATA_W-1:0] st_data_t;

   // per-thread LSU control register, 14 bits
   typedef struct packed {
      logic [`LSU_BMASK_W-1:0] vm;   // va watchpoint byte mask
      logic                    vr;
      logic                    vw;
      logic                    dm;
      logic                    im;
      logic                    dc;
      logic                    ic;
   } lsu_ctl_t;

   // thread in each pipe stage
   typedef struct packed {
      thread_id_t d;
      thread_id_t e;
      thread_id_t m;
      thread_id_t g;
   } stage_tid_t;

   // tte tag fields driven by the trap unit
   typedef struct packed {
      pid_t  pid;
      ctxt_t ctxt;
   } tte_tag_t;

   typedef enum logic [1:0] {
      CTXT_PRIMARY   = 2'd0,
      CTXT_SECONDARY = 2'd1,
      CTXT_ALTERNATE = 2'd2,
      CTXT_NONE      = 2'd3
   } ctxt_src_e;

   typedef enum logic [1:0] {
      LDXA_PCTXT = 2'd0,
      LDXA_SCTXT = 2'd1,
      LDXA_PID   = 2'd2,
      LDXA_CTL   = 2'd3
   } ldxa_src_e;

endpackage

`default_nettype wire

// File: hw/thread_state_bank.sv
// Per-thread register bank for one payload type; one write port, N_RD read ports by thread id.
`default_nettype none

`include "lsu_dctl_cfg.svh"

module thread_state_bank
   import lsu_dctl_pkg::*;
#(
   parameter type         T    = logic,
   parameter int unsigned N_RD = 1
) (
   input  wire             clk,
   input  wire             arst_n,
   input  wire logic       wr_en,
   input  wire thread_id_t wr_tid,
   input  wire T           wr_data,
   input  wire thread_id_t rd_tid [N_RD],
   output T                rd_data [N_RD]
);

   // one register per thread
   T regs [`LSU_NUM_THREADS];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `LSU_NUM_THREADS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_tid] <= wr_data;
      end
   end

   // read muxes, one per port
   for (genvar p = 0; p < N_RD; p++) begin : g_rd
      assign rd_data[p] = regs[rd_tid[p]];
   end

endmodule

`default_nettype wire

// File: hw/asi_pipe.sv
// ASI state registers with write source staging, immediate override and d-to-g staging.
`default_nettype none

module asi_pipe
   import lsu_dctl_pkg::*;
(
   input  wire             clk,
   input  wire             arst_n,
   input  wire stage_tid_t stage_tid,
   input  wire asi_t       tlu_asi,
   input  wire asi_t       wsr_data,
   input  wire logic       asi_wr,
   input  wire logic       asi_from_tlu,
   input  wire thread_id_t asi_wr_tid,
   input  wire asi_t       imm_asi,
   input  wire logic       imm_asi_vld,
   output asi_t            asi_d,
   output asi_t            asi_state_e,
   output asi_t            asi_state_m,
   output asi_t            asi_state_g,
   output asi_t            rsr_data_e
);

   asi_t       tlu_asi_q;
   asi_t       wsr_data_q;
   asi_t       asi_wr_data;
   thread_id_t asi_rd_tid [1];
   asi_t       asi_rd_data [1];

   // both write sources arrive a cycle ahead of the strobe
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tlu_asi_q  <= '0;
         wsr_data_q <= '0;
      end else begin
         tlu_asi_q  <= tlu_asi;
         wsr_data_q <= wsr_data;
      end
   end

   assign asi_wr_data = asi_from_tlu ? tlu_asi_q : wsr_data_q;

   assign asi_rd_tid[0] = stage_tid.d;

   thread_state_bank #(
      .T    (asi_t),
      .N_RD (1)
   ) u_asi_bank (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (asi_wr),
      .wr_tid  (asi_wr_tid),
      .wr_data (asi_wr_data),
      .rd_tid  (asi_rd_tid),
      .rd_data (asi_rd_data)
   );

   // immediate asi from the instruction wins
   assign asi_d = imm_asi_vld ? imm_asi : asi_rd_data[0];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         asi_state_e <= '0;
         asi_state_m <= '0;
         asi_state_g <= '0;
         rsr_data_e  <= '0;
      end else begin
         asi_state_e <= asi_d;
         asi_state_m <= asi_state_e;
         asi_state_g <= asi_state_m;
         // rdasi sees the register only, never the immediate
         rsr_data_e  <= asi_rd_data[0];
      end
   end

endmodule

`default_nettype wire

// File: hw/mmu_ctxt_sel.sv
// Context and partition id registers, TLB context select and m-stage context staging.
`default_nettype none

`include "lsu_dctl_cfg.svh"

module mmu_ctxt_sel
   import lsu_dctl_pkg::*;
(
   input  wire             clk,
   input  wire             arst_n,
   input  wire stage_tid_t stage_tid,
   input  wire st_data_t   st_data,
   input  wire thread_id_t st_tid,
   input  wire logic       pctxt_wr,
   input  wire logic       sctxt_wr,
   input  wire logic       pid_wr,
   input  wire ctxt_src_e  ctxt_src,
   input  wire thread_id_t ctxt_tid,
   input  wire tte_tag_t   tte_tag,
   input  wire logic       dmp_vld_e,
   output ctxt_t           tlb_ctxt,
   output ctxt_t           dside_ctxt_m,
   output ctxt_t           pctxt_m,
   output pid_t            cam_pid_e,
   output ctxt_t           pctxt_g,
   output ctxt_t           sctxt_g,
   output pid_t            pid_g
);

   thread_id_t pctxt_rd_tid [3];
   ctxt_t      pctxt_rd     [3];
   thread_id_t sctxt_rd_tid [2];
   ctxt_t      sctxt_rd     [2];
   thread_id_t pid_rd_tid   [2];
   pid_t       pid_rd       [2];

   // primary: lookup thread, e stage for the trap unit, g stage readback
   assign pctxt_rd_tid[0] = ctxt_tid;
   assign pctxt_rd_tid[1] = stage_tid.e;
   assign pctxt_rd_tid[2] = stage_tid.g;

   assign sctxt_rd_tid[0] = ctxt_tid;
   assign sctxt_rd_tid[1] = stage_tid.g;

   // pid: cam in e stage, readback in g stage
   assign pid_rd_tid[0] = stage_tid.e;
   assign pid_rd_tid[1] = stage_tid.g;

   thread_state_bank #(
      .T    (ctxt_t),
      .N_RD (3)
   ) u_pctxt_bank (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (pctxt_wr),
      .wr_tid  (st_tid),
      .wr_data (st_data[`LSU_CTXT_W-1:0]),
      .rd_tid  (pctxt_rd_tid),
      .rd_data (pctxt_rd)
   );

   thread_state_bank #(
      .T    (ctxt_t),
      .N_RD (2)
   ) u_sctxt_bank (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (sctxt_wr),
      .wr_tid  (st_tid),
      .wr_data (st_data[`LSU_CTXT_W-1:0]),
      .rd_tid  (sctxt_rd_tid),
      .rd_data (sctxt_rd)
   );

   thread_state_bank #(
      .T    (pid_t),
      .N_RD (2)
   ) u_pid_bank (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (pid_wr),
      .wr_tid  (st_tid),
      .wr_data (st_data[`LSU_PID_W-1:0]),
      .rd_tid  (pid_rd_tid),
      .rd_data (pid_rd)
   );

   // ctxt for translation or demap
   always_comb begin
      case (ctxt_src)
         CTXT_PRIMARY:   tlb_ctxt = pctxt_rd[0];
         CTXT_SECONDARY: tlb_ctxt = sctxt_rd[0];
         CTXT_ALTERNATE: tlb_ctxt = tte_tag.ctxt;
         default:        tlb_ctxt = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dside_ctxt_m <= '0;
         pctxt_m      <= '0;
      end else begin
         dside_ctxt_m <= tlb_ctxt;
         pctxt_m      <= pctxt_rd[1];
      end
   end

   // demap takes the pid from the tte tag
   assign cam_pid_e = dmp_vld_e ? tte_tag.pid : pid_rd[0];

   assign pctxt_g = pctxt_rd[2];
   assign sctxt_g = sctxt_rd[1];
   assign pid_g   = pid_rd[1];

endmodule

`default_nettype wire

// File: hw/lsu_ctl_regs.sv
// Per-thread LSU control registers with store data field extraction and watchpoint mask match.
`default_nettype none

`include "lsu_dctl_cfg.svh"

module lsu_ctl_regs
   import lsu_dctl_pkg::*;
(
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire stage_tid_t              stage_tid,
   input  wire st_data_t                st_data,
   input  wire thread_id_t              st_tid,
   input  wire logic                    ctl_wr,
   input  wire logic                    ctl_clr,
   input  wire logic [`LSU_BMASK_W-1:0] byte_mask,
   output logic                         wtchpt_match_m,
   output lsu_ctl_t                     ctl_g
);

   lsu_ctl_t   ctl_st;
   lsu_ctl_t   ctl_wr_data;
   logic       ctl_wr_en;
   thread_id_t ctl_rd_tid [2];
   lsu_ctl_t   ctl_rd     [2];

   // architectural bit positions in the store data
   always_comb begin
      ctl_st.ic = st_data[0];
      ctl_st.dc = st_data[1];
      ctl_st.im = st_data[2];
      ctl_st.dm = st_data[3];
      ctl_st.vw = st_data[21];
      ctl_st.vr = st_data[22];
      ctl_st.vm = st_data[32:25];
   end

   // clear has priority over the store
   assign ctl_wr_en   = ctl_wr | ctl_clr;
   assign ctl_wr_data = ctl_clr ? '0 : ctl_st;

   assign ctl_rd_tid[0] = stage_tid.m;
   assign ctl_rd_tid[1] = stage_tid.g;

   thread_state_bank #(
      .T    (lsu_ctl_t),
      .N_RD (2)
   ) u_ctl_bank (
      .clk     (clk),
      .arst_n  (arst_n),
      .wr_en   (ctl_wr_en),
      .wr_tid  (st_tid),
      .wr_data (ctl_wr_data),
      .rd_tid  (ctl_rd_tid),
      .rd_data (ctl_rd)
   );

   // byte mask bit i pairs with vm bit 7-i
   always_comb begin
      wtchpt_match_m = 1'b0;
      for (int i = 0; i < `LSU_BMASK_W; i++) begin
         wtchpt_match_m = wtchpt_match_m |
                          (byte_mask[i] & ctl_rd[0].vm[`LSU_BMASK_W-1-i]);
      end
   end

   assign ctl_g = ctl_rd[1];

endmodule

`default_nettype wire

// File: hw/ldxa_readback.sv
// Load-alternate readback: formats the g-stage registers and selects one 48-bit word.
`default_nettype none

`include "lsu_dctl_cfg.svh"

module ldxa_readback
   import lsu_dctl_pkg::*;
(
   input  wire ldxa_src_e              ldxa_src,
   input  wire ctxt_t                  pctxt_g,
   input  wire ctxt_t                  sctxt_g,
   input  wire pid_t                   pid_g,
   input  wire lsu_ctl_t               ctl_g,
   output logic [`LSU_LDXA_W-1:0]      ldxa_data_g
);

   logic [`LSU_LDXA_W-1:0] ctl_word;

   // vm 32:25, vr 22, vw 21, enables 3:0
   assign ctl_word = {{(`LSU_LDXA_W-33){1'b0}},
                      ctl_g.vm,
                      2'b00,
                      ctl_g.vr,
                      ctl_g.vw,
                      17'd0,
                      ctl_g.dm,
                      ctl_g.im,
                      ctl_g.dc,
                      ctl_g.ic};

   always_comb begin
      case (ldxa_src)
         LDXA_PCTXT: ldxa_data_g = {{(`LSU_LDXA_W-`LSU_CTXT_W){1'b0}}, pctxt_g};
         LDXA_SCTXT: ldxa_data_g = {{(`LSU_LDXA_W-`LSU_CTXT_W){1'b0}}, sctxt_g};
         LDXA_PID:   ldxa_data_g = {{(`LSU_LDXA_W-`LSU_PID_W){1'b0}}, pid_g};
         default:    ldxa_data_g = ctl_word;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/lsu_dctl_top.sv
// Top of the LSU control datapath; connects the ASI, context, control and readback blocks.
`default_nettype none

`include "lsu_dctl_cfg.svh"

module lsu_dctl_top
   import lsu_dctl_pkg::*;
(
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire stage_tid_t              stage_tid,
   // asi write and read
   input  wire asi_t                    tlu_asi,
   input  wire asi_t                    wsr_data,
   input  wire logic                    asi_wr,
   input  wire logic                    asi_from_tlu,
   input  wire thread_id_t              asi_wr_tid,
   input  wire asi_t                    imm_asi,
   input  wire logic                    imm_asi_vld,
   output asi_t                         asi_d,
   output asi_t                         asi_state_e,
   output asi_t                         asi_state_m,
   output asi_t                         asi_state_g,
   output asi_t                         rsr_data_e,
   // store data writes
   input  wire st_data_t                st_data,
   input  wire thread_id_t              st_tid,
   input  wire logic                    pctxt_wr,
   input  wire logic                    sctxt_wr,
   input  wire logic                    pid_wr,
   input  wire logic                    ctl_wr,
   input  wire logic                    ctl_clr,
   // tlb lookup
   input  wire ctxt_src_e               ctxt_src,
   input  wire thread_id_t              ctxt_tid,
   input  wire tte_tag_t                tte_tag,
   input  wire logic                    dmp_vld_e,
   output ctxt_t                        tlb_ctxt,
   output ctxt_t                        dside_ctxt_m,
   output ctxt_t                        pctxt_m,
   output pid_t                         cam_pid_e,
   // watchpoint and control
   input  wire logic [`LSU_BMASK_W-1:0] byte_mask,
   output logic                         wtchpt_match_m,
   output lsu_ctl_t                     ctl_g,
   // ldxa
   input  wire ldxa_src_e               ldxa_src,
   output logic [`LSU_LDXA_W-1:0]       ldxa_data_g
);

   ctxt_t pctxt_g;
   ctxt_t sctxt_g;
   pid_t  pid_g;

   asi_pipe u_asi_pipe (
      .clk          (clk),
      .arst_n       (arst_n),
      .stage_tid    (stage_tid),
      .tlu_asi      (tlu_asi),
      .wsr_data     (wsr_data),
      .asi_wr       (asi_wr),
      .asi_from_tlu (asi_from_tlu),
      .asi_wr_tid   (asi_wr_tid),
      .imm_asi      (imm_asi),
      .imm_asi_vld  (imm_asi_vld),
      .asi_d        (asi_d),
      .asi_state_e  (asi_state_e),
      .asi_state_m  (asi_state_m),
      .asi_state_g  (asi_state_g),
      .rsr_data_e   (rsr_data_e)
   );

   mmu_ctxt_sel u_mmu_ctxt_sel (
      .clk          (clk),
      .arst_n       (arst_n),
      .stage_tid    (stage_tid),
      .st_data      (st_data),
      .st_tid       (st_tid),
      .pctxt_wr     (pctxt_wr),
      .sctxt_wr     (sctxt_wr),
      .pid_wr       (pid_wr),
      .ctxt_src     (ctxt_src),
      .ctxt_tid     (ctxt_tid),
      .tte_tag      (tte_tag),
      .dmp_vld_e    (dmp_vld_e),
      .tlb_ctxt     (tlb_ctxt),
      .dside_ctxt_m (dside_ctxt_m),
      .pctxt_m      (pctxt_m),
      .cam_pid_e    (cam_pid_e),
      .pctxt_g      (pctxt_g),
      .sctxt_g      (sctxt_g),
      .pid_g        (pid_g)
   );

   lsu_ctl_regs u_lsu_ctl_regs (
      .clk            (clk),
      .arst_n         (arst_n),
      .stage_tid      (stage_tid),
      .st_data        (st_data),
      .st_tid         (st_tid),
      .ctl_wr         (ctl_wr),
      .ctl_clr        (ctl_clr),
      .byte_mask      (byte_mask),
      .wtchpt_match_m (wtchpt_match_m),
      .ctl_g          (ctl_g)
   );

   ldxa_readback u_ldxa_readback (
      .ldxa_src    (ldxa_src),
      .pctxt_g     (pctxt_g),
      .sctxt_g     (sctxt_g),
      .pid_g       (pid_g),
      .ctl_g       (ctl_g),
      .ldxa_data_g (ldxa_data_g)
   );

endmodule

`default_nettype wire

// File: sim/lsu_dctl_tb.sv
// Table-driven testbench for the LSU control datapath; simulate with lsu_dctl_tb as top.
`default_nettype none

`include "lsu_dctl_cfg.svh"

module lsu_dctl_tb
   import lsu_dctl_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_OPS      = 12;
   localparam int NUM_ROUNDS   = 16;
   localparam int NUM_ENTRIES  = NUM_OPS * NUM_ROUNDS;

   // store data bits that end up in the control register
   localparam logic [32:0] CTL_BITS = 33'h1_fe60_000f;

   typedef enum logic [3:0] {
      OP_ASI_TLU, OP_ASI_WSR, OP_PCTXT, OP_SCTXT, OP_PID, OP_CTL, OP_CLR,
      OP_ASI_RD, OP_TLB, OP_CAM, OP_WTCH, OP_LDXA
   } op_e;

   typedef struct packed {
      op_e                    op;
      thread_id_t             tid;
      logic [1:0]             sel;    // source select or valid flag
      logic [32:0]            data;
      logic [15:0]            aux;    // second expected value
      logic [`LSU_LDXA_W-1:0] exp;
   } entry_t;

   logic                    clk = 1'b0;
   logic                    arst_n;
   stage_tid_t              stage_tid;
   asi_t                    tlu_asi;
   asi_t                    wsr_data;
   logic                    asi_wr;
   logic                    asi_from_tlu;
   thread_id_t              asi_wr_tid;
   asi_t                    imm_asi;
   logic                    imm_asi_vld;
   asi_t                    asi_d;
   asi_t                    asi_state_e;
   asi_t                    asi_state_m;
   asi_t                    asi_state_g;
   asi_t                    rsr_data_e;
   st_data_t                st_data;
   thread_id_t              st_tid;
   logic                    pctxt_wr;
   logic                    sctxt_wr;
   logic                    pid_wr;
   logic                    ctl_wr;
   logic                    ctl_clr;
   ctxt_src_e               ctxt_src;
   thread_id_t              ctxt_tid;
   tte_tag_t                tte_tag;
   logic                    dmp_vld_e;
   ctxt_t                   tlb_ctxt;
   ctxt_t                   dside_ctxt_m;
   ctxt_t                   pctxt_m;
   pid_t                    cam_pid_e;
   logic [`LSU_BMASK_W-1:0] byte_mask;
   logic                    wtchpt_match_m;
   lsu_ctl_t                ctl_g;
   ldxa_src_e               ldxa_src;
   logic [`LSU_LDXA_W-1:0]  ldxa_data_g;

   // reference shadows with ctl kept as the masked store word
   asi_t        m_asi   [`LSU_NUM_THREADS];
   ctxt_t       m_pctxt [`LSU_NUM_THREADS];
   ctxt_t       m_sctxt [`LSU_NUM_THREADS];
   pid_t        m_pid   [`LSU_NUM_THREADS];
   logic [32:0] m_ctl   [`LSU_NUM_THREADS];

   entry_t table_q [NUM_ENTRIES];
   int     seed;
   int     cur_index;

   lsu_dctl_top DUT (.*);

   always #5 clk = ~clk;

   task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                 input string what);
      if (got !== exp) begin
         $display("MISMATCH at %0t ns: entry %0d %s got %0h expected %0h",
                  $time, cur_index, what, got, exp);
         $display("Finished with errors");
         $fatal(1, "value check failed");
      end
   endtask

   function automatic logic [7:0] reverse_bits(input logic [7:0] v);
      logic [7:0] r;
      for (int j = 0; j < 8; j++) begin
         r[j] = v[7-j];
      end
      return r;
   endfunction

   task automatic drive_idle();
      stage_tid    = '0;
      tlu_asi      = '0;
      wsr_data     = '0;
      asi_wr       = 1'b0;
      asi_from_tlu = 1'b0;
      asi_wr_tid   = '0;
      imm_asi      = '0;
      imm_asi_vld  = 1'b0;
      st_data      = '0;
      st_tid       = '0;
      pctxt_wr     = 1'b0;
      sctxt_wr     = 1'b0;
      pid_wr       = 1'b0;
      ctl_wr       = 1'b0;
      ctl_clr      = 1'b0;
      ctxt_src     = CTXT_NONE;
      ctxt_tid     = '0;
      tte_tag      = '0;
      dmp_vld_e    = 1'b0;
      byte_mask    = '0;
      ldxa_src     = LDXA_PCTXT;
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
      drive_idle();
   endtask

   // fills the table and runs the reference model alongside
   task automatic build_table();
      entry_t e;
      int     r;
      int     rnd_lo;
      int     rnd_hi;
      for (int t = 0; t < `LSU_NUM_THREADS; t++) begin
         m_asi[t]   = '0;
         m_pctxt[t] = '0;
         m_sctxt[t] = '0;
         m_pid[t]   = '0;
         m_ctl[t]   = '0;
      end
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         r      = i / NUM_OPS;
         rnd_lo = $random(seed);
         rnd_hi = $random(seed);
         e.op   = op_e'(i % NUM_OPS);
         e.sel  = r[1:0];
         e.data = {rnd_hi[0], rnd_lo[31:0]};
         e.aux  = '0;
         e.exp  = '0;
         // writes go to random threads, reads sweep all threads
         e.tid  = (e.op < OP_ASI_RD) ? rnd_hi[5:4] : r[3:2];
         case (e.op)
            OP_ASI_TLU, OP_ASI_WSR: m_asi[e.tid] = e.data[7:0];
            OP_PCTXT: m_pctxt[e.tid] = e.data[12:0];
            OP_SCTXT: m_sctxt[e.tid] = e.data[12:0];
            OP_PID:   m_pid[e.tid] = e.data[2:0];
            OP_CTL:   m_ctl[e.tid] = e.data & CTL_BITS;
            OP_CLR:   m_ctl[e.tid] = '0;
            OP_ASI_RD: begin
               e.aux = m_asi[e.tid];
               e.exp = e.sel[0] ? e.data[7:0] : m_asi[e.tid];
            end
            OP_TLB: begin
               e.aux = m_pctxt[e.tid];
               case (e.sel)
                  2'd0:    e.exp = m_pctxt[e.tid];
                  2'd1:    e.exp = m_sctxt[e.tid];
                  2'd2:    e.exp = e.data[12:0];
                  default: e.exp = '0;
               endcase
            end
            OP_CAM:  e.exp = e.sel[0] ? e.data[15:13] : m_pid[e.tid];
            OP_WTCH: e.exp = |(e.data[7:0] & reverse_bits(m_ctl[e.tid][32:25]));
            default: begin
               case (e.sel)
                  2'd0:    e.exp = m_pctxt[e.tid];
                  2'd1:    e.exp = m_sctxt[e.tid];
                  2'd2:    e.exp = m_pid[e.tid];
                  default: e.exp = m_ctl[e.tid];
               endcase
            end
         endcase
         table_q[i] = e;
      end
   endtask

   task automatic apply_entry(input entry_t e);
      next_cycle();
      case (e.op)
         OP_ASI_TLU, OP_ASI_WSR: begin
            tlu_asi  = (e.op == OP_ASI_TLU) ? e.data[7:0] : ~e.data[7:0];
            wsr_data = (e.op == OP_ASI_WSR) ? e.data[7:0] : ~e.data[7:0];
            // strobe one cycle later while the sources already show other values
            next_cycle();
            asi_wr       = 1'b1;
            asi_from_tlu = (e.op == OP_ASI_TLU);
            asi_wr_tid   = e.tid;
            tlu_asi      = ~e.data[7:0];
            wsr_data     = ~e.data[7:0];
         end
         OP_PCTXT, OP_SCTXT, OP_PID, OP_CTL, OP_CLR: begin
            st_data  = e.data;
            st_tid   = e.tid;
            pctxt_wr = (e.op == OP_PCTXT);
            sctxt_wr = (e.op == OP_SCTXT);
            pid_wr   = (e.op == OP_PID);
            ctl_wr   = (e.op == OP_CTL) || (e.op == OP_CLR);
            ctl_clr  = (e.op == OP_CLR);
         end
         OP_ASI_RD: begin
            stage_tid.d = e.tid;
            imm_asi_vld = e.sel[0];
            imm_asi     = e.data[7:0];
            #3;
            compare_values(asi_d, e.exp, "asi_d");
            // other values follow so a stage slip shows up
            for (int k = 1; k <= 3; k++) begin
               next_cycle();
               stage_tid.d = e.tid + 2'd1;
               imm_asi_vld = 1'b1;
               imm_asi     = ~e.exp[7:0];
               case (k)
                  1: begin
                     compare_values(rsr_data_e, e.aux, "rsr_data_e");
                     compare_values(asi_state_e, e.exp, "asi_state_e");
                  end
                  2:       compare_values(asi_state_m, e.exp, "asi_state_m");
                  default: compare_values(asi_state_g, e.exp, "asi_state_g");
               endcase
            end
         end
         OP_TLB: begin
            ctxt_src    = ctxt_src_e'(e.sel);
            ctxt_tid    = e.tid;
            tte_tag     = e.data[15:0];
            stage_tid.e = e.tid;
            #3;
            compare_values(tlb_ctxt, e.exp, "tlb_ctxt");
            next_cycle();
            compare_values(dside_ctxt_m, e.exp, "dside_ctxt_m");
            compare_values(pctxt_m, e.aux, "pctxt_m");
         end
         OP_CAM: begin
            stage_tid.e = e.tid;
            dmp_vld_e   = e.sel[0];
            tte_tag     = e.data[15:0];
            #3;
            compare_values(cam_pid_e, e.exp, "cam_pid_e");
         end
         OP_WTCH: begin
            stage_tid.m = e.tid;
            byte_mask   = e.data[7:0];
            #3;
            compare_values(wtchpt_match_m, e.exp, "wtchpt_match_m");
         end
         default: begin
            stage_tid.g = e.tid;
            ldxa_src    = ldxa_src_e'(e.sel);
            #3;
            compare_values(ldxa_data_g, e.exp, "ldxa_data_g");
            if (e.sel == 2'd3) begin
               compare_values(ctl_g, {e.exp[32:25], e.exp[22], e.exp[21], e.exp[3:0]},
                              "ctl_g");
            end
         end
      endcase
   endtask

   initial begin
      seed      = 32'h3f5d_569c;
      cur_index = -1;
      arst_n    = 1'b0;
      drive_idle();
      build_table();
      repeat (8) @(posedge clk);
      #1;
      arst_n    = 1'b1;
      ctxt_src  = CTXT_PRIMARY;
      byte_mask = '1;
      #3;
      compare_values(asi_d, 0, "asi_d after reset");
      compare_values(tlb_ctxt, 0, "tlb_ctxt after reset");
      compare_values(cam_pid_e, 0, "cam_pid_e after reset");
      compare_values(wtchpt_match_m, 0, "wtchpt_match_m after reset");
      for (int s = 0; s < 4; s++) begin
         @(posedge clk);
         #1;
         ldxa_src = ldxa_src_e'(s);
         #3;
         compare_values(ldxa_data_g, 0, "ldxa_data_g after reset");
      end
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         cur_index = i;
         apply_entry(table_q[i]);
      end
      next_cycle();
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hw/lsu_dctl_pkg.sv
hw/thread_state_bank.sv
hw/asi_pipe.sv
hw/mmu_ctxt_sel.sv
hw/lsu_ctl_regs.sv
hw/ldxa_readback.sv
hw/lsu_dctl_top.sv
sim/lsu_dctl_tb.sv

// File: Bender.yml
package:
  name: lsu_dctl

sources:
  - include_dirs:
      - include
    files:
      - hw/lsu_dctl_pkg.sv
      - hw/thread_state_bank.sv
      - hw/asi_pipe.sv
      - hw/mmu_ctxt_sel.sv
      - hw/lsu_ctl_regs.sv
      - hw/ldxa_readback.sv
      - hw/lsu_dctl_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/lsu_dctl_tb.sv
